// File: include/l3c_config.svh
`ifndef L3C_CONFIG_SVH
`define L3C_CONFIG_SVH

`define L3C_ADDR_W 16 // Word address bits
`define L3C_DATA_W 32 // Bits per data word
`define L3C_INDEX_W 4 // 16 lines
`define L3C_OFFSET_W 2 // 4 words per line

// Derived geometry
`define L3C_TAG_W (`L3C_ADDR_W - `L3C_INDEX_W - `L3C_OFFSET_W)
`define L3C_LINE_W (`L3C_ADDR_W - `L3C_OFFSET_W) // Tag plus index
`define L3C_LINES (1 << `L3C_INDEX_W)
`define L3C_WORDS (1 << `L3C_OFFSET_W)

`endif

// File: logic/l3c_addr_pkg.sv
`include "l3c_config.svh"

// Widths of the address fields and data words
// Word address layout, MSB first: tag, index, offset
package l3c_addr_pkg;

	typedef logic [`L3C_ADDR_W-1:0] word_adr_t; // Full word address
	typedef logic [`L3C_DATA_W-1:0] data_t; // One bus word

	typedef logic [`L3C_TAG_W-1:0] tag_t; // Upper address bits
	typedef logic [`L3C_INDEX_W-1:0] index_t; // Selects the line
	typedef logic [`L3C_OFFSET_W-1:0] offset_t; // Word within line

	typedef logic [`L3C_LINE_W-1:0] line_adr_t; // Line aligned, {tag, index}

endpackage

// File: logic/l3c_ctrl_pkg.sv
// Controller state encoding
package l3c_ctrl_pkg;

	typedef enum logic [2:0] {
		ST_FREE = 3'd0, // Idle, waiting for request or fence
		ST_TAG = 3'd1, // Tag lookup
		ST_EVICT = 3'd2, // Dirty line write back
		ST_REFILL = 3'd3, // Line fetch from memory
		ST_RSPRD = 3'd4, // Read ack
		ST_RSPWR = 3'd5, // Write ack
		ST_FENCE = 3'd6 // Flush scan
	} l3c_state_t;

endpackage

// File: logic/l3c_intf.sv
// Controller to tag array
interface l3c_tag_if import l3c_addr_pkg::*; ();
	word_adr_t lookup_adr; // Request address
	logic write_tag; // Load tag of indexed line
	logic set_valid; // Mark line valid and clean
	logic set_dirty; // Mark line modified
	logic invalidate; // Drop line
	index_t scan_index; // Fence line pointer
	logic scan_sel; // Index from scan_index
	logic hit;
	logic victim_valid;
	logic victim_dirty;
	tag_t victim_tag;

	modport state (output lookup_adr, write_tag, set_valid, set_dirty, invalidate,
		scan_index, scan_sel, input hit, victim_valid, victim_dirty, victim_tag);
	modport array (input lookup_adr, write_tag, set_valid, set_dirty, invalidate,
		scan_index, scan_sel, output hit, victim_valid, victim_dirty, victim_tag);
endinterface

// Two port data storage, A for CPU words, B for line moves
interface l3c_data_if import l3c_addr_pkg::*; ();
	index_t a_index;
	offset_t a_offset;
	logic a_we;
	data_t a_wdata;
	data_t a_rdata; // One cycle after address
	index_t b_index;
	offset_t b_offset;
	logic b_we;
	data_t b_wdata;
	data_t b_rdata; // One cycle after address

	modport cpu (output a_index, a_offset, a_we, a_wdata, input a_rdata);
	modport fill (output b_index, b_offset, b_we, b_wdata, input b_rdata);
	modport array (input a_index, a_offset, a_we, a_wdata, b_index, b_offset, b_we,
		b_wdata, output a_rdata, b_rdata);
endinterface

// Line transfer request to the memory port
interface l3c_xfer_if import l3c_addr_pkg::*; ();
	logic start; // One cycle pulse
	logic write_back; // 1 evict, 0 refill
	line_adr_t line_adr;
	logic done; // Pulse after last word

	modport ctrl (output start, write_back, line_adr, input done);
	modport port (input start, write_back, line_adr, output done);
endinterface

// File: logic/l3c_state.sv
`include "l3c_config.svh"

module l3c_state import l3c_addr_pkg::*, l3c_ctrl_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input word_adr_t wb_adr,
	input data_t wb_dat_w,
	output data_t wb_dat_r,
	output logic wb_ack,
	input logic fence_req,
	output logic fence_ack,
	l3c_tag_if.state tag,
	l3c_data_if.cpu data,
	l3c_xfer_if.ctrl xfer
);

	l3c_state_t state;
	l3c_state_t state_nxt;

	logic req_pend; // Request captured, not yet looked up
	word_adr_t req_adr;
	logic req_we;
	data_t req_dat;

	logic fence_act; // Fence scan in progress
	index_t scan_cnt; // Line under scan
	index_t cur_index; // Index the tag array is looking at
	logic evict_need; // Indexed line valid and dirty
	logic scan_last;

	logic start_q;
	logic wb_q;
	line_adr_t line_q;

	assign cur_index = fence_act ? scan_cnt : req_adr[`L3C_OFFSET_W +: `L3C_INDEX_W];
	assign evict_need = tag.victim_valid & tag.victim_dirty;
	assign scan_last = (scan_cnt == index_t'(`L3C_LINES - 1));

	// Next state
	always_comb begin
		state_nxt = state;
		unique case (state)
			ST_FREE: begin
				if (fence_req)
					state_nxt = ST_FENCE; // Fence wins over a new request
				else if (req_pend)
					state_nxt = ST_TAG;
			end
			ST_TAG: begin
				if (tag.hit)
					state_nxt = req_we ? ST_RSPWR : ST_RSPRD;
				else if (evict_need)
					state_nxt = ST_EVICT;
				else
					state_nxt = ST_REFILL; // Empty or clean victim
			end
			ST_EVICT: begin
				if (xfer.done)
					state_nxt = fence_act ? ST_FENCE : ST_TAG;
			end
			ST_REFILL: begin
				if (xfer.done)
					state_nxt = ST_TAG; // Looks up again, now hits
			end
			ST_RSPRD, ST_RSPWR: state_nxt = ST_FREE;
			ST_FENCE: begin
				if (evict_need)
					state_nxt = ST_EVICT;
				else if (scan_last)
					state_nxt = ST_FREE;
			end
			default: state_nxt = ST_FREE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_FREE;
			req_pend <= 1'b0;
			fence_act <= 1'b0;
			scan_cnt <= '0;
			start_q <= 1'b0;
		end else begin
			state <= state_nxt;
			if (state == ST_FREE && !req_pend && wb_cyc && wb_stb)
				req_pend <= 1'b1; // Sample upstream request
			else if (state == ST_FREE && state_nxt == ST_TAG)
				req_pend <= 1'b0;
			if (state == ST_FREE && fence_req)
				fence_act <= 1'b1;
			else if (fence_ack)
				fence_act <= 1'b0;
			if (state == ST_FENCE && !evict_need)
				scan_cnt <= scan_cnt + 1'b1; // Wraps to 0 at the end
			start_q <= (state == ST_TAG || state == ST_FENCE) &&
				(state_nxt == ST_EVICT || state_nxt == ST_REFILL);
		end
	end

	// Request and transfer payload
	always_ff @(posedge clk) begin
		if (state == ST_FREE && !req_pend) begin
			req_adr <= wb_adr;
			req_we <= wb_we;
			req_dat <= wb_dat_w;
		end
		if (state_nxt == ST_EVICT) begin
			wb_q <= 1'b1;
			line_q <= {tag.victim_tag, cur_index}; // Victim line
		end else if (state_nxt == ST_REFILL) begin
			wb_q <= 1'b0;
			line_q <= req_adr[`L3C_ADDR_W-1:`L3C_OFFSET_W]; // Requested line
		end
	end

	assign xfer.start = start_q;
	assign xfer.write_back = wb_q;
	assign xfer.line_adr = line_q;

	assign tag.lookup_adr = req_adr;
	assign tag.scan_sel = fence_act;
	assign tag.scan_index = scan_cnt;
	assign tag.write_tag = (state == ST_REFILL) && xfer.done;
	assign tag.set_valid = (state == ST_REFILL) && xfer.done; // New line is clean
	assign tag.set_dirty = (state == ST_RSPWR);
	assign tag.invalidate = ((state == ST_EVICT) && xfer.done) ||
		((state == ST_FENCE) && !evict_need); // Written back or fence drop

	assign data.a_index = req_adr[`L3C_OFFSET_W +: `L3C_INDEX_W];
	assign data.a_offset = req_adr[`L3C_OFFSET_W-1:0];
	assign data.a_we = (state == ST_RSPWR);
	assign data.a_wdata = req_dat;

	assign wb_dat_r = data.a_rdata; // Valid in ST_RSPRD
	assign wb_ack = (state == ST_RSPRD) || (state == ST_RSPWR);
	assign fence_ack = (state == ST_FENCE) && !evict_need && scan_last;

endmodule

// File: logic/l3c_tag_array.sv
`include "l3c_config.svh"

module l3c_tag_array import l3c_addr_pkg::*; (
	input logic clk,
	input logic rst_n,
	l3c_tag_if.array tag
);

	logic [`L3C_LINES-1:0] valid;
	logic [`L3C_LINES-1:0] dirty;
	tag_t tag_mem [`L3C_LINES]; // Stored tag per line

	index_t idx;
	tag_t lookup_tag;

	assign lookup_tag = tag.lookup_adr[`L3C_ADDR_W-1 -: `L3C_TAG_W];
	assign idx = tag.scan_sel ? tag.scan_index
		: tag.lookup_adr[`L3C_OFFSET_W +: `L3C_INDEX_W]; // Fence scan or lookup

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid <= '0;
			dirty <= '0;
		end else if (tag.invalidate) begin
			valid[idx] <= 1'b0;
			dirty[idx] <= 1'b0;
		end else begin
			if (tag.set_valid) begin
				valid[idx] <= 1'b1;
				dirty[idx] <= 1'b0; // Fresh from memory
			end
			if (tag.set_dirty)
				dirty[idx] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (tag.write_tag)
			tag_mem[idx] <= lookup_tag;
	end

	// Combinational results for the indexed line
	assign tag.hit = valid[idx] && (tag_mem[idx] == lookup_tag);
	assign tag.victim_valid = valid[idx];
	assign tag.victim_dirty = dirty[idx];
	assign tag.victim_tag = tag_mem[idx];

endmodule

// File: logic/l3c_data_array.sv
`include "l3c_config.svh"

module l3c_data_array import l3c_addr_pkg::*; (
	input logic clk,
	l3c_data_if.array data
);

	// Flat storage, word address {index, offset}
	data_t mem [`L3C_LINES * `L3C_WORDS];

	// Both ports in one process, never writing together
	always_ff @(posedge clk) begin
		if (data.a_we)
			mem[{data.a_index, data.a_offset}] <= data.a_wdata; // CPU write hit
		if (data.b_we)
			mem[{data.b_index, data.b_offset}] <= data.b_wdata; // Refill word
		data.a_rdata <= mem[{data.a_index, data.a_offset}]; // Old data on collision
		data.b_rdata <= mem[{data.b_index, data.b_offset}];
	end

endmodule

// File: logic/l3c_mem_port.sv
`include "l3c_config.svh"

module l3c_mem_port import l3c_addr_pkg::*; (
	input logic clk,
	input logic rst_n,
	l3c_xfer_if.port xfer,
	l3c_data_if.fill data,
	output logic mem_cyc,
	output logic mem_stb,
	output logic mem_we,
	output word_adr_t mem_adr,
	output data_t mem_dat_w,
	input data_t mem_dat_r,
	input logic mem_ack
);

	logic busy; // Line transfer running
	logic fetch; // Waiting on port B read for write back
	logic cyc_q; // Bus cycle open
	logic done_q;
	logic wb_q;
	line_adr_t line_q;
	offset_t cnt; // Word in line
	logic last_word;

	assign last_word = (cnt == offset_t'(`L3C_WORDS - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			fetch <= 1'b0;
			cyc_q <= 1'b0;
			done_q <= 1'b0;
			cnt <= '0;
		end else begin
			done_q <= 1'b0;
			if (xfer.start && !busy) begin
				busy <= 1'b1;
				cnt <= '0;
				fetch <= xfer.write_back; // Write back reads word first
				cyc_q <= !xfer.write_back;
			end else if (fetch) begin
				fetch <= 1'b0;
				cyc_q <= 1'b1; // b_rdata valid from here
			end else if (cyc_q && mem_ack) begin
				if (last_word) begin
					cyc_q <= 1'b0;
					busy <= 1'b0;
					done_q <= 1'b1;
				end else begin
					cnt <= cnt + 1'b1;
					cyc_q <= !wb_q; // Refill keeps the bus
					fetch <= wb_q;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (xfer.start && !busy) begin
			wb_q <= xfer.write_back;
			line_q <= xfer.line_adr;
		end
	end

	// Port B stays on the current word, read data holds
	assign data.b_index = line_q[`L3C_INDEX_W-1:0];
	assign data.b_offset = cnt;
	assign data.b_we = cyc_q && mem_ack && !wb_q; // Store returned word
	assign data.b_wdata = mem_dat_r;

	assign mem_cyc = cyc_q;
	assign mem_stb = cyc_q;
	assign mem_we = wb_q;
	assign mem_adr = {line_q, cnt};
	assign mem_dat_w = data.b_rdata;
	assign xfer.done = done_q;

endmodule

// File: logic/l3cache.sv
module l3cache import l3c_addr_pkg::*; (
	input logic clk,
	input logic rst_n,
	// Upstream slave
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input word_adr_t wb_adr,
	input data_t wb_dat_w,
	output data_t wb_dat_r,
	output logic wb_ack,
	// Downstream master to memory
	output logic mem_cyc,
	output logic mem_stb,
	output logic mem_we,
	output word_adr_t mem_adr,
	output data_t mem_dat_w,
	input data_t mem_dat_r,
	input logic mem_ack,
	// Flush and invalidate
	input logic fence_req,
	output logic fence_ack
);

	l3c_tag_if tag_if ();
	l3c_data_if data_if ();
	l3c_xfer_if xfer_if ();

	l3c_state u_state (
		.clk (clk),
		.rst_n (rst_n),
		.wb_cyc (wb_cyc),
		.wb_stb (wb_stb),
		.wb_we (wb_we),
		.wb_adr (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack (wb_ack),
		.fence_req (fence_req),
		.fence_ack (fence_ack),
		.tag (tag_if.state),
		.data (data_if.cpu),
		.xfer (xfer_if.ctrl)
	);

	l3c_tag_array u_tag_array (
		.clk (clk),
		.rst_n (rst_n),
		.tag (tag_if.array)
	);

	l3c_data_array u_data_array (
		.clk (clk),
		.data (data_if.array)
	);

	l3c_mem_port u_mem_port (
		.clk (clk),
		.rst_n (rst_n),
		.xfer (xfer_if.port),
		.data (data_if.fill),
		.mem_cyc (mem_cyc),
		.mem_stb (mem_stb),
		.mem_we (mem_we),
		.mem_adr (mem_adr),
		.mem_dat_w (mem_dat_w),
		.mem_dat_r (mem_dat_r),
		.mem_ack (mem_ack)
	);

endmodule

// File: verification/l3cache_sva.sv
module l3cache_sva import l3c_addr_pkg::*, l3c_ctrl_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_ack,
	input logic mem_cyc,
	input logic mem_stb,
	input logic mem_we,
	input word_adr_t mem_adr,
	input data_t mem_dat_w,
	input logic mem_ack,
	input logic fence_req,
	input logic fence_ack,
	input l3c_state_t state
);

	timeunit 1ns;
	timeprecision 1ps;

	// Downstream master holds its request until ack
	mem_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(mem_stb && !mem_ack) |=> (mem_stb && $stable(mem_adr) && $stable(mem_we)))
		else $error("mem request changed before ack");
	mem_wdat_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(mem_stb && mem_we && !mem_ack) |=> $stable(mem_dat_w))
		else $error("mem write data changed before ack");
	// Memory bus only moves a line during eviction or refill
	mem_in_xfer: assert property (@(posedge clk) disable iff (!rst_n)
		mem_cyc |-> (state == ST_EVICT || state == ST_REFILL))
		else $error("mem cycle outside eviction or refill");

	// Upstream ack lasts one cycle and needs a live request
	wb_ack_req: assert property (@(posedge clk) disable iff (!rst_n)
		wb_ack |-> (wb_cyc && wb_stb))
		else $error("wb_ack without request");
	wb_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		wb_ack |=> !wb_ack)
		else $error("wb_ack longer than one cycle");

	fence_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		fence_ack |=> !fence_ack)
		else $error("fence_ack longer than one cycle");
	fence_in_scan: assert property (@(posedge clk) disable iff (!rst_n)
		fence_ack |-> (fence_req && !mem_cyc))
		else $error("fence_ack without a request or with a memory cycle open");

endmodule

bind l3cache l3cache_sva sva0 (
	.clk (clk),
	.rst_n (rst_n),
	.wb_cyc (wb_cyc),
	.wb_stb (wb_stb),
	.wb_ack (wb_ack),
	.mem_cyc (mem_cyc),
	.mem_stb (mem_stb),
	.mem_we (mem_we),
	.mem_adr (mem_adr),
	.mem_dat_w (mem_dat_w),
	.mem_ack (mem_ack),
	.fence_req (fence_req),
	.fence_ack (fence_ack),
	.state (u_state.state)
);

// File: verification/l3cache_checker.sv
module l3cache_checker import l3c_addr_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input word_adr_t wb_adr,
	input data_t wb_dat_w,
	input data_t wb_dat_r,
	input logic wb_ack,
	input int test_id
);

	timeunit 1ns;
	timeprecision 1ps;

	localparam int REF_WORDS = 1024;
	localparam int HIT_LAT = 2; // Ack two cycles after sampling

	data_t ref_mem [REF_WORDS]; // Expected memory image
	int error_count;
	int reads_checked;
	int lat; // Edges with request pending
	int last_lat;

	function automatic string test_label(input int id);
		case (id)
			1: return "read_after_reset";
			2: return "write_read_hit";
			3: return "conflict_evict";
			4: return "random_mix";
			5: return "fence_flush";
			6: return "read_after_fence";
			default: return "unknown";
		endcase
	endfunction

	function automatic data_t init_word(input int a);
		logic [9:0] w;
		w = a[9:0];
		return {w, 6'h15, ~w, w[5:0] ^ w[9:4]};
	endfunction

	initial begin
		error_count = 0;
		reads_checked = 0;
		lat = 0;
		last_lat = 0;
		for (int i = 0; i < REF_WORDS; i++)
			ref_mem[i] = init_word(i);
	end

	// Bus values sampled before the edge updates them
	always @(posedge clk) begin
		if (!rst_n)
			lat = 0;
		else if (wb_cyc && wb_stb) begin
			if (wb_ack) begin
				last_lat = lat - 1; // Sampling edge not counted
				lat = 0;
				if (wb_we)
					ref_mem[wb_adr[9:0]] = wb_dat_w;
				else begin
					reads_checked++;
					if (wb_dat_r !== ref_mem[wb_adr[9:0]]) begin
						error_count++;
						$display("** Error %s: read adr %h expected %h actual %h",
							test_label(test_id), wb_adr, ref_mem[wb_adr[9:0]], wb_dat_r);
					end
				end
			end else
				lat++;
		end
	end

	task automatic check_hit_latency();
		if (last_lat != HIT_LAT) begin
			error_count++;
			$display("** Error %s: hit ack latency expected %0d actual %0d",
				test_label(test_id), HIT_LAT, last_lat);
		end
	endtask

	task automatic expect_miss();
		if (last_lat <= HIT_LAT) begin
			error_count++;
			$display("** Error %s: miss ack latency expected above %0d actual %0d",
				test_label(test_id), HIT_LAT, last_lat);
		end
	endtask

	task automatic compare_word(input int adr, input data_t got);
		if (got !== ref_mem[adr]) begin
			error_count++;
			$display("** Error %s: memory adr %h expected %h actual %h",
				test_label(test_id), adr, ref_mem[adr], got);
		end
	endtask

endmodule

// File: verification/l3cache_tb.sv
module l3cache_tb import l3c_addr_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [31:0] SEED = 32'h2e5e;
	localparam int CLK_PERIOD = 100;
	localparam int N_INIT = 16; // Reads after reset
	localparam int N_MIX = 300; // Random reads and writes
	localparam int N_POST = 16; // Reads after fence
	localparam int N_FENCE = 16; // Fence counted as one request per line
	localparam int N_REQ = N_INIT + 2 + 4 + N_MIX + N_POST + N_FENCE;
	localparam int MISS_BOUND = 2 * 4 * 5 + 10; // Evict plus refill in cycles
	localparam int MEM_WORDS = 1024;
	localparam int ADR_RANGE_W = 8; // Stimulus stays in 256 words

	logic clk;
	logic rst_n;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	word_adr_t wb_adr;
	data_t wb_dat_w;
	data_t wb_dat_r;
	logic wb_ack;
	logic mem_cyc;
	logic mem_stb;
	logic mem_we;
	word_adr_t mem_adr;
	data_t mem_dat_w;
	data_t mem_dat_r;
	logic mem_ack;
	logic fence_req;
	logic fence_ack;
	int test_id;

	logic [31:0] lfsr;
	data_t mem_model [MEM_WORDS]; // Downstream memory contents
	int mem_wait;
	logic mem_busy;
	int err_mark;
	int tests_run;
	int tests_failed;

	l3cache dut0 (.*);

	l3cache_checker chk0 (
		.clk (clk),
		.rst_n (rst_n),
		.wb_cyc (wb_cyc),
		.wb_stb (wb_stb),
		.wb_we (wb_we),
		.wb_adr (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack (wb_ack),
		.test_id (test_id)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	// Galois form with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr); // One step per bit
			v = {v[30:0], lfsr[0]};
		end
	endtask

	// Power-up content depends on every address bit
	function automatic data_t init_word(input int a);
		logic [9:0] w;
		w = a[9:0];
		return {w, 6'h15, ~w, w[5:0] ^ w[9:4]};
	endfunction

	// Memory slave acks after 0 to 3 wait cycles
	always @(negedge clk) begin
		logic [31:0] r;
		if (!rst_n) begin
			mem_ack = 1'b0;
			mem_busy = 1'b0;
		end else if (mem_ack) begin
			mem_ack = 1'b0; // One cycle ack
			mem_busy = 1'b0;
		end else if (mem_cyc && mem_stb) begin
			if (!mem_busy) begin
				take_bits(2, r);
				mem_wait = int'(r);
				mem_busy = 1'b1;
			end else
				mem_wait = mem_wait - 1;
			if (mem_wait == 0) begin
				mem_ack = 1'b1;
				if (mem_we)
					mem_model[mem_adr[9:0]] = mem_dat_w;
				else
					mem_dat_r = mem_model[mem_adr[9:0]];
			end
		end
	end

	// One upstream transfer held until ack is sampled
	task automatic bus_access(input logic we, input word_adr_t adr, input data_t wdat);
		@(negedge clk);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_w = wdat;
		do
			@(negedge clk);
		while (!wb_ack);
		@(negedge clk); // Ack taken at the edge before
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	task automatic random_adr(output word_adr_t adr);
		logic [31:0] r;
		take_bits(ADR_RANGE_W, r);
		adr = word_adr_t'(r[ADR_RANGE_W-1:0]);
	endtask

	task automatic finish_test();
		int errs;
		errs = chk0.error_count - err_mark;
		$display("test %0d %s: %s, %0d errors", test_id, chk0.test_label(test_id),
			(errs == 0) ? "ok" : "FAILED", errs);
		tests_run++;
		if (errs != 0)
			tests_failed++;
		err_mark = chk0.error_count;
	endtask

	// Runaway guard sized by a worst case miss per request
	initial begin
		#(CLK_PERIOD * (N_REQ * MISS_BOUND + 30));
		$display("Timeout: the DUT stopped answering before all tests ended");
		$display("Test failed");
		$finish;
	end

	initial begin
		word_adr_t a;
		word_adr_t b;
		logic [31:0] r;
		rst_n = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		mem_dat_r = '0;
		mem_ack = 1'b0;
		mem_busy = 1'b0;
		mem_wait = 0;
		fence_req = 1'b0;
		test_id = 1;
		err_mark = 0;
		tests_run = 0;
		tests_failed = 0;
		lfsr = SEED;
		for (int i = 0; i < MEM_WORDS; i++)
			mem_model[i] = init_word(i);
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// Cold reads that all refill
		for (int i = 0; i < N_INIT; i++) begin
			random_adr(a);
			bus_access(1'b0, a, '0);
		end
		finish_test();

		// Write then read back as a hit
		test_id = 2;
		take_bits(32, r);
		bus_access(1'b1, 16'h005a, r);
		bus_access(1'b0, 16'h005a, '0);
		chk0.check_hit_latency();
		finish_test();

		// Same index with tags one apart
		test_id = 3;
		a = 16'h0013;
		b = a + 16'h0040;
		take_bits(32, r);
		bus_access(1'b1, a, r);
		take_bits(32, r);
		bus_access(1'b1, b, r); // Evicts dirty a
		bus_access(1'b0, a, '0);
		bus_access(1'b0, b, '0);
		finish_test();

		test_id = 4;
		for (int i = 0; i < N_MIX; i++) begin
			random_adr(a);
			take_bits(1, r);
			if (r[0]) begin
				take_bits(32, r);
				bus_access(1'b1, a, r);
			end else
				bus_access(1'b0, a, '0);
		end
		finish_test();

		// Flush before the memory compare
		test_id = 5;
		@(negedge clk);
		fence_req = 1'b1;
		while (!fence_ack)
			@(negedge clk);
		@(negedge clk); // Held through the ack edge
		fence_req = 1'b0;
		for (int i = 0; i < MEM_WORDS; i++)
			chk0.compare_word(i, mem_model[i]);
		finish_test();

		test_id = 6;
		for (int i = 0; i < N_POST; i++) begin
			random_adr(a);
			bus_access(1'b0, a, '0);
			if (i == 0)
				chk0.expect_miss(); // Fence left every line invalid
		end
		finish_test();

		$display("tests: %0d run, %0d failed, %0d errors, %0d reads checked",
			tests_run, tests_failed, chk0.error_count, chk0.reads_checked);
		if (tests_failed == 0 && chk0.reads_checked > 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: l3cache.f
+incdir+include
logic/l3c_addr_pkg.sv
logic/l3c_ctrl_pkg.sv
logic/l3c_intf.sv
logic/l3c_state.sv
logic/l3c_tag_array.sv
logic/l3c_data_array.sv
logic/l3c_mem_port.sv
logic/l3cache.sv
verification/l3cache_sva.sv
verification/l3cache_checker.sv
verification/l3cache_tb.sv

// File: run.sh
#!/bin/sh
# Build and run with Verilator, fail on the fail message or a missing pass
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f l3cache.f --top-module l3cache_tb \
	-Mdir obj_dir > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/Vl3cache_tb > sim.log 2>&1
cat sim.log
! grep -q "Test failed" sim.log && grep -q "Test completed successfully" sim.log \
	&& exit 0 || exit 1
